// File: hdl/px_pkg.sv
/*
	Shared types for the PX state control unit.
	Holds the cycle length class, the interrupt phase encoding
	and the system bus controller states.
	Modules import it with a wildcard inside their body and
	name the types with scoped names in their port lists.
*/

package px_pkg;

	// Strob1 delay class, chosen by the active state
	typedef enum logic {
		LEN_SHORT = 1'b0,	// Plain states
		LEN_LONG  = 1'b1	// WZ or P4 active, slower strob1
	} cyc_len_t;

	// Interrupt sequencer phases
	typedef enum logic [2:0] {
		I_IDLE = 3'd0,	// No interrupt in progress
		I_1    = 3'd1,	// Entry phase
		I_2    = 3'd2,	// Vector fetch
		I_3    = 3'd3,	// Decide save or restore
		I_4    = 3'd4,	// Context save
		I_5    = 3'd5	// Context restore
	} intr_phase_t;

	// System bus controller states
	typedef enum logic [1:0] {
		BUS_IDLE  = 2'd0,	// No request
		BUS_REQ   = 2'd1,	// zg high, waiting for ren_ or rok_
		BUS_DONE  = 2'd2,	// Acknowledge seen, bus_ok pulse
		BUS_ALARM = 2'd3	// Timeout, alarm and bus_ok pulse
	} bus_state_t;

endpackage

// File: hdl/px_state_regs.sv
/*
	Main state flip-flops of the PX unit.
	Each state takes its enter input on the cyc_end cycle and holds
	for the whole next machine cycle. Outputs are active low.
	Also decodes the strob1 length class and whether the current
	state needs a system bus transfer.
*/

`timescale 1ns/1ps

module px_state_regs (
	input  logic              got,		// System clock
	input  logic              clo_,		// General clear
	input  logic              cyc_end,	// End of machine cycle
	input  logic              ek1,		// Enter K1
	input  logic              ek2,		// Enter K2
	input  logic              ewp,		// Enter WP
	input  logic              ewa,		// Enter WA
	input  logic              ewr,		// Enter WR
	input  logic              eww,		// Enter WW
	input  logic              ewz,		// Enter WZ
	input  logic              ep0,		// Enter P0
	input  logic              ep1,		// Enter P1
	input  logic              ep4,		// Enter P4
	output logic              k1_,
	output logic              k2_,
	output logic              wp_,
	output logic              wa_,
	output logic              wr_,
	output logic              ww_,
	output logic              wz_,
	output logic              p0_,
	output logic              p1_,
	output logic              p4_,
	output px_pkg::cyc_len_t  len_class,	// Strob1 delay class
	output logic              bus_need_st	// State wants the bus
);

	import px_pkg::*;

	logic k1, k2, wp, wa, wr, ww, wz, p0, p1, p4;	// State levels, active high

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			{k1, k2, wp, wa, wr, ww, wz, p1, p4} <= '0;
			p0 <= 1'b1;	// Machine comes up in P0
		end else if (cyc_end) begin
			{k1, k2, wp, wa, wr, ww, wz, p0, p1, p4} <=
				{ek1, ek2, ewp, ewa, ewr, eww, ewz, ep0, ep1, ep4};
		end
	end

	assign {k1_, k2_, wp_, wa_, wr_, ww_, wz_, p0_, p1_, p4_} =
		~{k1, k2, wp, wa, wr, ww, wz, p0, p1, p4};

	assign len_class   = (wz | p4) ? LEN_LONG : LEN_SHORT;	// Slow strob1 for WZ and P4
	assign bus_need_st = k1 | p1 | wr | ww;			// Memory access states

endmodule

// File: hdl/px_strobgen.sv
/*
	Machine cycle timer.
	Produces strob1, strob2 and cyc_end as one-cycle pulses, counted in
	got cycles from cycle start. When a bus transfer is pending, strob2
	waits for bus_ok instead of the fixed delay. In step mode the cycle
	end is held until step_ is seen low at or after strob2.
*/

`timescale 1ns/1ps

module px_strobgen #(
	parameter int STROB1_SHORT = 2,	// Cycle start to strob1, short class
	parameter int STROB1_LONG  = 4,	// Cycle start to strob1, long class
	parameter int STROB2_TICKS = 2	// strob1 to strob2 without bus
) (
	input  logic              got,
	input  logic              clo_,
	input  logic              mode,		// High selects single step
	input  logic              step_,	// Step request, active low
	input  px_pkg::cyc_len_t  len_class,
	input  logic              bus_busy,	// Transfer requested
	input  logic              bus_ok,	// Transfer finished
	output logic              strob1,
	output logic              strob2,
	output logic              cyc_end
);

	import px_pkg::*;

	localparam int CNT_MAX = (STROB1_LONG > STROB1_SHORT) ?
		((STROB1_LONG > STROB2_TICKS) ? STROB1_LONG : STROB2_TICKS) :
		((STROB1_SHORT > STROB2_TICKS) ? STROB1_SHORT : STROB2_TICKS);
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [1:0] {
		PH_S1   = 2'd0,	// Counting to strob1
		PH_S2   = 2'd1,	// Counting or waiting for strob2
		PH_STEP = 2'd2,	// Waiting for step_
		PH_END  = 2'd3	// cyc_end cycle
	} phase_t;

	phase_t           phase;
	logic [CNT_W-1:0] cnt;		// Cycles spent in current phase
	logic             bus_path;	// Latched at strob1, strob2 waits for bus_ok
	logic [CNT_W-1:0] s1_last;	// Last count before strob1
	logic             use_bus;
	logic             step_go;	// Cycle may end now

	assign s1_last = (len_class == LEN_LONG) ? CNT_W'(STROB1_LONG - 1) :
		CNT_W'(STROB1_SHORT - 1);
	assign use_bus = strob1 ? bus_busy : bus_path;	// bus_busy is fresh on strob1
	assign step_go = !mode || !step_;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			phase    <= PH_S1;
			cnt      <= '0;
			bus_path <= 1'b0;
			strob1   <= 1'b0;
			strob2   <= 1'b0;
		end else begin
			strob1 <= 1'b0;
			strob2 <= 1'b0;
			if (strob1)
				bus_path <= bus_busy;
			case (phase)
				PH_S1: begin
					if (cnt == s1_last) begin
						strob1 <= 1'b1;
						phase  <= PH_S2;
						cnt    <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				PH_S2: begin
					if (use_bus ? bus_ok : (cnt == CNT_W'(STROB2_TICKS - 1))) begin
						strob2 <= 1'b1;
						phase  <= PH_STEP;
					end else if (!use_bus) begin
						cnt <= cnt + 1'b1;
					end
				end
				PH_STEP: if (step_go) phase <= PH_END;	// strob2 cycle and after
				PH_END: begin
					phase <= PH_S1;	// Next cycle is cycle start
					cnt   <= '0;
				end
				default: phase <= PH_S1;
			endcase
		end
	end

	assign cyc_end = (phase == PH_END);

endmodule

// File: hdl/px_intr_seq.sv
/*
	Interrupt phase sequencer, phases I1 to I5.
	One step per machine cycle, taken on cyc_end. si1 starts the
	sequence, przerw_ picks the vector fetch and lip picks between
	context save and restore. Phase outputs are active low.
*/

`timescale 1ns/1ps

module px_intr_seq (
	input  logic got,
	input  logic clo_,
	input  logic cyc_end,		// End of machine cycle
	input  logic si1,		// Start interrupt, set I1
	input  logic przerw_,		// Interrupt pending, fetch vector
	input  logic lip,		// Return from interrupt
	output logic i1_,
	output logic i2_,
	output logic i3_,
	output logic i4_,
	output logic i5_,
	output logic bus_need_i		// Phase needs a bus transfer
);

	import px_pkg::*;

	intr_phase_t phase;
	intr_phase_t phase_nxt;

	always_comb begin
		phase_nxt = phase;
		case (phase)
			I_IDLE: if (si1) phase_nxt = I_1;
			I_1:    phase_nxt = przerw_ ? I_3 : I_2;	// Skip fetch without przerw_
			I_2:    phase_nxt = I_3;
			I_3:    phase_nxt = lip ? I_5 : I_4;	// Restore on lip
			I_4:    phase_nxt = I_IDLE;
			I_5:    phase_nxt = I_IDLE;
			default: phase_nxt = I_IDLE;		// Unused codes fall back
		endcase
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_)
			phase <= I_IDLE;
		else if (cyc_end)
			phase <= phase_nxt;
	end

	// Active-low phase levels
	assign i1_ = (phase != I_1);
	assign i2_ = (phase != I_2);
	assign i3_ = (phase != I_3);
	assign i4_ = (phase != I_4);
	assign i5_ = (phase != I_5);

	// Vector fetch, save and restore all touch memory
	assign bus_need_i = (phase == I_2) || (phase == I_4) || (phase == I_5);

endmodule

// File: hdl/px_bus_ctl.sv
/*
	System bus controller.
	On strob1 with a pending need it raises zg and waits for ren_ or
	rok_. An acknowledge or a timeout of ALARM_TICKS cycles ends the
	wait with a bus_ok pulse. A timeout also pulses alarm and latches
	awaria_ low until stop_ is pulled low or the unit is reset.
*/

`timescale 1ns/1ps

module px_bus_ctl #(
	parameter int ALARM_TICKS = 8	// Wait before alarm
) (
	input  logic got,
	input  logic clo_,
	input  logic strob1,
	input  logic bus_need_st,	// From state regs
	input  logic bus_need_i,	// From interrupt sequencer
	input  logic ren_,		// Acknowledge, memory present
	input  logic rok_,		// Acknowledge, transfer ok
	input  logic stop_,		// Clears failure latch
	output logic zg,		// Bus request
	output logic bus_busy,
	output logic bus_ok,
	output logic alarm,
	output logic awaria_		// Failure flag, active low
);

	import px_pkg::*;

	localparam int CNT_W = $clog2(ALARM_TICKS + 1);

	bus_state_t       state;
	logic [CNT_W-1:0] cnt;		// Cycles with zg high
	logic             need;
	logic             ack;
	logic             awaria;	// Failure latch, active high

	assign need = bus_need_st | bus_need_i;
	assign ack  = zg && (!ren_ || !rok_);	// Only counts while requesting

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= BUS_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				BUS_IDLE: begin
					if (strob1 && need) begin
						state <= BUS_REQ;
						cnt   <= '0;
					end
				end
				BUS_REQ: begin
					if (ack)
						state <= BUS_DONE;	// Ack wins over timeout
					else if (cnt == CNT_W'(ALARM_TICKS - 1))
						state <= BUS_ALARM;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= BUS_IDLE;	// DONE and ALARM last one cycle
			endcase
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_)
			awaria <= 1'b0;
		else if (!stop_)
			awaria <= 1'b0;
		else if (alarm)
			awaria <= 1'b1;
	end

	assign zg       = (state == BUS_REQ);
	assign bus_busy = (strob1 && need) || (state == BUS_REQ);
	assign bus_ok   = (state == BUS_DONE) || (state == BUS_ALARM);
	assign alarm    = (state == BUS_ALARM);
	assign awaria_  = ~awaria;

endmodule

// File: hdl/px.sv
/*
	PX state control unit, top level.
	Ties together the state flip-flops, the machine cycle timer,
	the interrupt sequencer and the system bus controller, and sets
	the timing parameters that are passed down to them.
*/

`timescale 1ns/1ps

module px #(
	parameter int STROB1_SHORT = 2,	// Short class strob1 delay
	parameter int STROB1_LONG  = 4,	// Long class strob1 delay
	parameter int STROB2_TICKS = 2,	// strob1 to strob2 without bus
	parameter int ALARM_TICKS  = 8	// Acknowledge timeout
) (
	input  logic got,
	input  logic clo_,
	input  logic mode,
	input  logic step_,
	input  logic ek1,
	input  logic ek2,
	input  logic ewp,
	input  logic ewa,
	input  logic ewr,
	input  logic eww,
	input  logic ewz,
	input  logic ep0,
	input  logic ep1,
	input  logic ep4,
	input  logic si1,
	input  logic przerw_,
	input  logic lip,
	input  logic ren_,
	input  logic rok_,
	input  logic stop_,
	output logic k1_,
	output logic k2_,
	output logic wp_,
	output logic wa_,
	output logic wr_,
	output logic ww_,
	output logic wz_,
	output logic p0_,
	output logic p1_,
	output logic p4_,
	output logic i1_,
	output logic i2_,
	output logic i3_,
	output logic i4_,
	output logic i5_,
	output logic strob1,
	output logic strob2,
	output logic cyc_end,
	output logic zg,
	output logic alarm,
	output logic awaria_
);

	px_pkg::cyc_len_t len_class;	// State regs to timer
	logic bus_need_st;
	logic bus_need_i;
	logic bus_busy;			// Bus controller to timer
	logic bus_ok;

	px_state_regs u_state (
		.got(got), .clo_(clo_), .cyc_end(cyc_end),
		.ek1(ek1), .ek2(ek2), .ewp(ewp), .ewa(ewa), .ewr(ewr),
		.eww(eww), .ewz(ewz), .ep0(ep0), .ep1(ep1), .ep4(ep4),
		.k1_(k1_), .k2_(k2_), .wp_(wp_), .wa_(wa_), .wr_(wr_),
		.ww_(ww_), .wz_(wz_), .p0_(p0_), .p1_(p1_), .p4_(p4_),
		.len_class(len_class), .bus_need_st(bus_need_st)
	);

	px_strobgen #(
		.STROB1_SHORT(STROB1_SHORT),
		.STROB1_LONG(STROB1_LONG),
		.STROB2_TICKS(STROB2_TICKS)
	) u_strob (
		.got(got), .clo_(clo_), .mode(mode), .step_(step_),
		.len_class(len_class), .bus_busy(bus_busy), .bus_ok(bus_ok),
		.strob1(strob1), .strob2(strob2), .cyc_end(cyc_end)
	);

	px_intr_seq u_intr (
		.got(got), .clo_(clo_), .cyc_end(cyc_end),
		.si1(si1), .przerw_(przerw_), .lip(lip),
		.i1_(i1_), .i2_(i2_), .i3_(i3_), .i4_(i4_), .i5_(i5_),
		.bus_need_i(bus_need_i)
	);

	px_bus_ctl #(
		.ALARM_TICKS(ALARM_TICKS)
	) u_bus (
		.got(got), .clo_(clo_), .strob1(strob1),
		.bus_need_st(bus_need_st), .bus_need_i(bus_need_i),
		.ren_(ren_), .rok_(rok_), .stop_(stop_),
		.zg(zg), .bus_busy(bus_busy), .bus_ok(bus_ok),
		.alarm(alarm), .awaria_(awaria_)
	);

endmodule

// File: test/px_tb.sv
/*
	Self-checking testbench for the PX state control unit.
	Runs random machine cycles with random acknowledge delays, then an
	alarm case, both interrupt paths and single-step mode.
	Concurrent assertions do all checking and the closing line prints
	the error counts.
*/

`timescale 1ns/1ps

module px_tb;

	import px_pkg::*;

	localparam int STROB1_SHORT = 2;	// Same as dut0 defaults
	localparam int STROB1_LONG  = 4;
	localparam int STROB2_TICKS = 2;
	localparam int ALARM_TICKS  = 8;
	localparam int WAIT_MAX     = 64;	// Cycles per wait loop
	localparam logic [9:0] EN_K1 = 10'b10_0000_0000;	// Enter order K1 first, P4 last
	localparam logic [9:0] EN_WZ = 10'b00_0000_1000;
	localparam logic [9:0] EN_P0 = 10'b00_0000_0100;

	logic got, clo_, mode, step_, si1, przerw_, lip, ren_, rok_, stop_;
	logic ek1, ek2, ewp, ewa, ewr, eww, ewz, ep0, ep1, ep4;
	logic k1_, k2_, wp_, wa_, wr_, ww_, wz_, p0_, p1_, p4_;
	logic i1_, i2_, i3_, i4_, i5_;
	logic strob1, strob2, cyc_end, zg, alarm, awaria_;

	logic [9:0]  st_;	// State levels, active low
	logic [9:0]  en;	// Enter inputs in the same order
	logic [4:0]  ph_;	// i1_ to i5_
	intr_phase_t iph;	// Phase seen on the outputs
	logic        need;	// Current state or phase needs the bus
	logic        step_wait = 1'b0;	// Between strob2 and cyc_end
	logic [15:0] lfsr = 16'd45;
	int          err_cnt = 0;
	int          tmo_cnt = 0;
	int          ack_dly = 0;	// Cycles of zg before ack, negative means none
	logic        ack_sel = 1'b0;	// Acknowledge on rok_ when set

	px dut0 (.*);

	assign st_  = {k1_, k2_, wp_, wa_, wr_, ww_, wz_, p0_, p1_, p4_};
	assign en   = {ek1, ek2, ewp, ewa, ewr, eww, ewz, ep0, ep1, ep4};
	assign ph_  = {i1_, i2_, i3_, i4_, i5_};
	assign need = !k1_ || !p1_ || !wr_ || !ww_ || iph == I_2 || iph == I_4 || iph == I_5;

	always_comb begin
		case (ph_)
			5'b01111: iph = I_1;
			5'b10111: iph = I_2;
			5'b11011: iph = I_3;
			5'b11101: iph = I_4;
			5'b11110: iph = I_5;
			default:  iph = I_IDLE;
		endcase
	end

	always @(posedge got or negedge clo_) begin
		if (!clo_)
			step_wait <= 1'b0;
		else if (strob2)
			step_wait <= 1'b1;
		else if (cyc_end)
			step_wait <= 1'b0;
	end

	initial begin
		got = 1'b0;
		forever #5 got = ~got;
	end

	task automatic log_error(input string msg);
		err_cnt++;
		$display("[ERROR] t=%0t %s", $time, msg);
	endtask

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			val  = (val << 1) | lfsr[0];
		end
	endtask

	task automatic next_cycle();
		@(posedge got);
		#1;	// Drive and look just after the edge
	endtask

	task automatic wait_pulse(input string name);
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < WAIT_MAX && !seen; n++) begin
			next_cycle();
			seen = (name == "cyc_end") ? cyc_end : (name == "strob1") ? strob1 : strob2;
		end
		if (!seen) begin
			tmo_cnt++;
			$display("Timeout: no %s within %0d cycles at t=%0t", name, WAIT_MAX, $time);
		end
	endtask

	// Called at cycle start, returns at the next cycle start
	task automatic machine_cycle(input logic [9:0] enter, input logic s1, input int dly,
		input int hold);
		{ek1, ek2, ewp, ewa, ewr, eww, ewz, ep0, ep1, ep4} = enter;
		si1     = s1;
		ack_dly = dly;
		step_   = (hold < 0) ? 1'b0 : 1'b1;	// Negative hold keeps step_ low all cycle
		if (mode && hold >= 0) begin
			wait_pulse("strob2");
			repeat (hold) next_cycle();	// Cycle must stay open here
			step_ = 1'b0;
		end
		wait_pulse("cyc_end");
		next_cycle();
	endtask

	task automatic random_cycle();
		int v;
		int dly;
		int b;
		take_bits(10, v);
		take_bits(3, dly);
		dly = dly % 6;
		take_bits(1, b);
		ack_sel = b[0];
		take_bits(1, b);
		lip = b[0];
		take_bits(1, b);
		przerw_ = b[0];
		take_bits(2, b);
		machine_cycle(v[9:0], &b[1:0], dly, 0);	// si1 about one cycle in four
	endtask

	task automatic interrupt_run(input logic pz, input logic lp);
		przerw_ = pz;
		lip     = lp;
		machine_cycle(EN_P0, 1'b1, 1, 0);
		repeat (5) machine_cycle(EN_P0, 1'b0, 1, 0);	// Ends back in I_IDLE
	endtask

	// Acknowledge responder, idle whenever zg is low
	initial begin
		int zg_cycles;
		ren_      = 1'b1;
		rok_      = 1'b1;
		zg_cycles = 0;
		forever begin
			next_cycle();
			if (zg) begin
				zg_cycles++;
				if (ack_dly >= 0 && zg_cycles > ack_dly) begin
					ren_ = ack_sel;
					rok_ = !ack_sel;
				end
			end else begin
				zg_cycles = 0;
				ren_      = 1'b1;
				rok_      = 1'b1;
			end
		end
	end

	initial begin
		clo_    = 1'b0;
		mode    = 1'b0;
		step_   = 1'b1;
		si1     = 1'b0;
		przerw_ = 1'b1;
		lip     = 1'b0;
		stop_   = 1'b1;
		{ek1, ek2, ewp, ewa, ewr, eww, ewz, ep0, ep1, ep4} = '0;
		repeat (3) @(posedge got);
		#1 clo_ = 1'b1;

		repeat (40) random_cycle();

		machine_cycle(EN_K1, 1'b0, 2, 0);	// K1 active in the next cycle
		machine_cycle(EN_P0, 1'b0, -1, 0);	// No acknowledge, alarm
		repeat (4) machine_cycle(EN_P0, 1'b0, 1, 0);
		stop_ = 1'b0;
		next_cycle();
		stop_ = 1'b1;
		repeat (2) machine_cycle(EN_P0, 1'b0, 1, 0);

		interrupt_run(1'b0, 1'b0);	// I1 I2 I3 I4
		interrupt_run(1'b1, 1'b1);	// I1 I3 I5

		mode = 1'b1;
		machine_cycle(EN_P0, 1'b0, 1, 0);
		machine_cycle(EN_WZ, 1'b0, 1, 5);
		machine_cycle(EN_K1, 1'b0, 3, 3);
		machine_cycle(EN_P0, 1'b0, 2, 4);	// Bus cycle in step mode
		repeat (2) machine_cycle(EN_P0, 1'b0, 1, -1);
		mode  = 1'b0;
		step_ = 1'b1;
		repeat (4) next_cycle();

		$display("Failed checks: %0d, timeouts: %0d", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Reset values, seen on the first edge after clo_ rises
	assert property (@(posedge got) $rose(clo_) |-> st_ == 10'b11_1111_1011 && &ph_
		&& !zg && !alarm && !strob1 && !strob2 && !cyc_end && awaria_)
		else log_error("outputs wrong after reset");

	assert property (@(posedge got) disable iff (!clo_) cyc_end |=> st_ == ~$past(en))
		else log_error("state levels do not match enter inputs taken at cyc_end");
	assert property (@(posedge got) disable iff (!clo_) !cyc_end |=> $stable(st_))
		else log_error("state levels changed without cyc_end");

	assert property (@(posedge got) disable iff (!clo_)
		cyc_end ##1 (wz_ && p4_) |-> !strob1 [*STROB1_SHORT] ##1 strob1)
		else log_error("short class strob1 delay wrong");
	assert property (@(posedge got) disable iff (!clo_)
		cyc_end ##1 (!wz_ || !p4_) |-> !strob1 [*STROB1_LONG] ##1 strob1)
		else log_error("long class strob1 delay wrong");
	assert property (@(posedge got) disable iff (!clo_)
		strob1 && !need |-> !strob2 [*STROB2_TICKS] ##1 strob2)
		else log_error("strob2 delay without bus wrong");

	// Bus request and acknowledge
	assert property (@(posedge got) disable iff (!clo_) strob1 |=> zg == $past(need))
		else log_error("zg does not follow bus need after strob1");
	assert property (@(posedge got) disable iff (!clo_)
		zg && !(ren_ && rok_) |=> !zg ##1 strob2)
		else log_error("zg or strob2 wrong after acknowledge");
	assert property (@(posedge got) disable iff (!clo_)
		(zg && ren_ && rok_) [*ALARM_TICKS] |=> alarm && !zg ##1 strob2)
		else log_error("no alarm after acknowledge timeout");
	assert property (@(posedge got) disable iff (!clo_) $rose(zg) |-> !alarm [*ALARM_TICKS])
		else log_error("alarm before timeout");
	assert property (@(posedge got) disable iff (!clo_) alarm |=> !alarm)
		else log_error("alarm longer than one cycle");

	// Failure latch
	assert property (@(posedge got) disable iff (!clo_) alarm && stop_ |=> !awaria_)
		else log_error("awaria_ not set by alarm");
	assert property (@(posedge got) disable iff (!clo_) !stop_ |=> awaria_)
		else log_error("awaria_ not released by stop_");
	assert property (@(posedge got) disable iff (!clo_) stop_ && !alarm |=> $stable(awaria_))
		else log_error("awaria_ changed without alarm or stop_");

	// Cycle end, normal and step mode
	assert property (@(posedge got) disable iff (!clo_)
		(strob2 || step_wait) && !cyc_end && (!mode || !step_) |=> cyc_end)
		else log_error("cyc_end missing after strob2 or step");
	assert property (@(posedge got) disable iff (!clo_) mode && step_ |=> !cyc_end)
		else log_error("cyc_end without step in step mode");
	assert property (@(posedge got) disable iff (!clo_)
		cyc_end |-> $past((strob2 || step_wait) && (!mode || !step_)))
		else log_error("cyc_end out of sequence");
	assert property (@(posedge got) disable iff (!clo_) cyc_end |=> !cyc_end)
		else log_error("cyc_end longer than one cycle");

	// Interrupt phases
	assert property (@(posedge got) disable iff (!clo_) $countones(ph_) >= 4)
		else log_error("more than one interrupt phase active");
	assert property (@(posedge got) disable iff (!clo_)
		cyc_end && iph == I_IDLE |=> iph == ($past(si1) ? I_1 : I_IDLE))
		else log_error("wrong phase after idle");
	assert property (@(posedge got) disable iff (!clo_)
		cyc_end && iph == I_1 |=> iph == ($past(przerw_) ? I_3 : I_2))
		else log_error("wrong phase after I1");
	assert property (@(posedge got) disable iff (!clo_) cyc_end && iph == I_2 |=> iph == I_3)
		else log_error("wrong phase after I2");
	assert property (@(posedge got) disable iff (!clo_)
		cyc_end && iph == I_3 |=> iph == ($past(lip) ? I_5 : I_4))
		else log_error("wrong phase after I3");
	assert property (@(posedge got) disable iff (!clo_)
		cyc_end && (iph == I_4 || iph == I_5) |=> iph == I_IDLE)
		else log_error("no return to idle after I4 or I5");
	assert property (@(posedge got) disable iff (!clo_) !cyc_end |=> $stable(iph))
		else log_error("interrupt phase changed without cyc_end");

endmodule

// File: px.f
hdl/px_pkg.sv
hdl/px_state_regs.sv
hdl/px_strobgen.sv
hdl/px_intr_seq.sv
hdl/px_bus_ctl.sv
hdl/px.sv
test/px_tb.sv

// File: Bender.yml
package:
  name: px

sources:
  - hdl/px_pkg.sv
  - hdl/px_state_regs.sv
  - hdl/px_strobgen.sv
  - hdl/px_intr_seq.sv
  - hdl/px_bus_ctl.sv
  - hdl/px.sv
  - target: test
    files:
      - test/px_tb.sv
